// File: Makefile
# Verilator build and run for the instruction buffer testbench
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = ibufTb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# The log decides pass or fail, the simulator status is kept out of it
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
+incdir+src
src/ibufPkg.sv
src/ibufIfs.sv
src/ibufConfigRegs.sv
src/ibufWriteAlloc.sv
src/ibufStorage.sv
src/ibufDispatchCtrl.sv
src/instBuffer.sv
testbench/ibufTb.sv

// File: src/ibufConfigRegs.sv
// Wishbone classic register block for lane and partition settings
`default_nettype none
`include "ibuf_consts.svh"

module ibufConfigRegs (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        wbCyc_i,
	input  wire                        wbStb_i,
	input  wire                        wbWe_i,
	input  wire  [`WB_ADR_WIDTH-1:0]   wbAdr_i,
	input  wire  [`WB_DAT_WIDTH-1:0]   wbDat_i,
	input  wire  ibufPkg::queueCount   count_i,
	output logic [`WB_DAT_WIDTH-1:0]   wbDat_o,
	output logic                       wbAck_o,
	ibufCfgIf.source                   cfg
);
	ibufPkg::laneCount         dispatchLanes;
	ibufPkg::laneCount         fetchLanes;
	ibufPkg::laneCount         queueParts;
	logic                      wbReq;
	logic [`WB_DAT_WIDTH-1:0]  rdData;

	// Clamp a written count into 1 .. maxVal
	function automatic ibufPkg::laneCount saturate(input logic [2:0] value,
		input int unsigned maxVal);
		ibufPkg::laneCount result;
		if (value == 3'd0)
			result = 3'd1;
		else if (32'(value) > maxVal)
			result = ibufPkg::laneCount'(maxVal);
		else
			result = value;
		return result;
	endfunction

	// New request only while ack is low, so ack is a single cycle
	assign wbReq = wbCyc_i & wbStb_i & ~wbAck_o;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wbAck_o       <= 1'b0;
			dispatchLanes <= ibufPkg::laneCount'(`DISPATCH_WIDTH);
			fetchLanes    <= ibufPkg::laneCount'(`FETCH_WIDTH);
			queueParts    <= ibufPkg::laneCount'(`QUEUE_PARTS);
		end
		else
		begin
			wbAck_o <= wbReq;
			// Write lands on the edge that raises ack
			if (wbReq & wbWe_i)
			begin
				case (wbAdr_i)
					`REG_LANES:
					begin
						dispatchLanes <= saturate(wbDat_i[2:0], `DISPATCH_WIDTH);
						fetchLanes    <= saturate({1'b0, wbDat_i[5:4]}, `FETCH_WIDTH);
					end
					`REG_PARTS:
						queueParts <= saturate(wbDat_i[2:0], `QUEUE_PARTS);
					// Count is read-only, unmapped writes dropped
					default:
					begin
					end
				endcase
			end
		end
	end

	// Read mux, unmapped offsets read zero
	always_comb
	begin
		rdData = '0;
		case (wbAdr_i)
			`REG_LANES:
			begin
				rdData[2:0] = dispatchLanes;
				rdData[5:4] = fetchLanes[1:0];
			end
			`REG_PARTS:
				rdData[2:0] = queueParts;
			`REG_COUNT:
				rdData[`INST_QUEUE_LOG:0] = count_i;
			default:
				rdData = '0;
		endcase
	end

	// Data only presented during the ack cycle
	assign wbDat_o = wbAck_o ? rdData : '0;

	// Lane masks, contiguous from lane 0
	always_comb
	begin
		for (int i = 0; i < `DISPATCH_WIDTH; i++)
			cfg.dispatchLaneMask[i] = ibufPkg::laneCount'(i) < dispatchLanes;
		for (int i = 0; i < `FETCH_WIDTH; i++)
			cfg.fetchLaneMask[i] = ibufPkg::laneCount'(i) < fetchLanes;
	end

	assign cfg.numDispatchLanes = dispatchLanes;
	assign cfg.numFetchLanes    = fetchLanes;
	assign cfg.queueSize        = ibufPkg::queueCount'(queueParts) *
		ibufPkg::queueCount'(`INST_QUEUE / `QUEUE_PARTS);

endmodule

`default_nettype wire

// File: src/ibufDispatchCtrl.sv
// Head pointer, occupancy, CSR and exception serialization, output squashing
`default_nettype none
`include "ibuf_consts.svh"

module ibufDispatchCtrl (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        flush_i,
	input  wire                        stall_i,
	input  wire                        commitCsr_i,
	input  wire  ibufPkg::laneCount    numWritten_i,
	input  wire  ibufPkg::ibufPacket   rdData_i [0:`DISPATCH_WIDTH-1],
	ibufCfgIf.sink                     cfg,
	output ibufPkg::queueIndex         rdAddr_o [0:`DISPATCH_WIDTH-1],
	output ibufPkg::queueCount         count_o,
	output logic                       ready_o,
	output logic                       stallForCsr_o,
	output logic                       insufficient_o,
	output ibufPkg::ibufPacket         renPacket_o [0:`DISPATCH_WIDTH-1]
);
	ibufPkg::queueIndex          headPtr;
	ibufPkg::queueCount          instCount;
	ibufPkg::queueCount          countNext;
	ibufPkg::queueCount          headSum;
	ibufPkg::queueCount          numLanes;
	ibufPkg::laneCount           dispatched;
	logic [`DISPATCH_WIDTH-1:0]  inCount;
	logic [`DISPATCH_WIDTH-1:0]  laneMask;
	logic                        csrDispatched;
	logic                        excptDispatched;
	logic                        stallForCsr;
	logic                        stallForExcpt;

	assign numLanes = ibufPkg::queueCount'(cfg.numDispatchLanes);

	// Read from head onward, wrapping at the configured size
	always_comb
	begin
		ibufPkg::queueCount addr;
		for (int i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			addr = ibufPkg::queueCount'(headPtr) + ibufPkg::queueCount'(i);
			if (addr >= cfg.queueSize)
				addr = addr - cfg.queueSize;
			rdAddr_o[i] = ibufPkg::queueIndex'(addr);
			// Lane holds a real entry
			inCount[i] = instCount > ibufPkg::queueCount'(i);
		end
	end

	// Whole bundle needed before anything leaves
	assign ready_o = (instCount >= numLanes) & ~stall_i & ~stallForCsr & ~stallForExcpt;

	// A CSR or excepting instruction closes the bundle behind it
	always_comb
	begin
		logic [`DISPATCH_WIDTH-1:0] mask;
		mask[0] = ~stall_i & cfg.dispatchLaneMask[0];
		for (int i = 1; i < `DISPATCH_WIDTH; i++)
			mask[i] = mask[i-1] & inCount[i-1] & ~stall_i & cfg.dispatchLaneMask[i] &
				~(rdData_i[i-1].isCsr | rdData_i[i-1].exception);
		laneMask = mask;
	end

	// Squash control bits of lanes that do not leave, payload untouched
	always_comb
	begin
		logic keep;
		for (int i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			keep = ready_o & laneMask[i] & inCount[i];
			renPacket_o[i]           = rdData_i[i];
			renPacket_o[i].valid     = keep & rdData_i[i].valid;
			renPacket_o[i].isCsr     = keep & rdData_i[i].isCsr;
			renPacket_o[i].exception = keep & rdData_i[i].exception;
			renPacket_o[i].isLoad    = keep & rdData_i[i].isLoad;
			renPacket_o[i].isStore   = keep & rdData_i[i].isStore;
		end
	end

	// Lanes leaving now, and whether one of them serializes
	always_comb
	begin
		ibufPkg::laneCount n;
		n               = '0;
		csrDispatched   = 1'b0;
		excptDispatched = 1'b0;
		for (int i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			n               = n + ibufPkg::laneCount'(renPacket_o[i].valid);
			csrDispatched   = csrDispatched | renPacket_o[i].isCsr;
			excptDispatched = excptDispatched | renPacket_o[i].exception;
		end
		dispatched = n;
	end

	assign countNext = instCount + ibufPkg::queueCount'(numWritten_i) -
		ibufPkg::queueCount'(dispatched);
	assign headSum   = ibufPkg::queueCount'(headPtr) + ibufPkg::queueCount'(dispatched);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			headPtr   <= '0;
			instCount <= '0;
		end
		else if (flush_i)
		begin
			headPtr   <= '0;
			instCount <= '0;
		end
		else
		begin
			instCount <= countNext;
			if (headSum >= cfg.queueSize)
				headPtr <= ibufPkg::queueIndex'(headSum - cfg.queueSize);
			else
				headPtr <= ibufPkg::queueIndex'(headSum);
		end
	end

	// CSR hold released by commit, exception hold only by flush
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stallForCsr   <= 1'b0;
			stallForExcpt <= 1'b0;
		end
		else if (flush_i)
		begin
			stallForCsr   <= 1'b0;
			stallForExcpt <= 1'b0;
		end
		else
		begin
			if (commitCsr_i)
				stallForCsr <= 1'b0;
			else if (csrDispatched)
				stallForCsr <= 1'b1;
			if (excptDispatched)
				stallForExcpt <= 1'b1;
		end
	end

	assign stallForCsr_o = stallForCsr | stallForExcpt;

	// Too few entries now and next cycle, safe hint for reconfiguration
	assign insufficient_o = (instCount < numLanes) & (countNext < numLanes);
	assign count_o        = instCount;

endmodule

`default_nettype wire

// File: src/ibufIfs.sv
// Write port bundle and configuration bundle interfaces
`default_nettype none
`include "ibuf_consts.svh"

// Compacted writes from the allocator into the storage
interface ibufWriteIf;
	logic                wrEn   [0:`WRITE_PORTS-1];
	ibufPkg::queueIndex  wrAddr [0:`WRITE_PORTS-1];
	ibufPkg::ibufPacket  wrData [0:`WRITE_PORTS-1];
	// Packets actually taken this cycle
	ibufPkg::laneCount   numWritten;

	modport source (
		output wrEn,
		output wrAddr,
		output wrData,
		output numWritten
	);

	modport sink (
		input  wrEn,
		input  wrAddr,
		input  wrData
	);
endinterface

// Run-time lane and partition settings
interface ibufCfgIf;
	ibufPkg::fetchMask     fetchLaneMask;
	ibufPkg::dispatchMask  dispatchLaneMask;
	ibufPkg::laneCount     numFetchLanes;
	ibufPkg::laneCount     numDispatchLanes;
	// Effective depth, partitions times 8
	ibufPkg::queueCount    queueSize;

	modport source (
		output fetchLaneMask,
		output dispatchLaneMask,
		output numFetchLanes,
		output numDispatchLanes,
		output queueSize
	);

	modport sink (
		input  fetchLaneMask,
		input  dispatchLaneMask,
		input  numFetchLanes,
		input  numDispatchLanes,
		input  queueSize
	);
endinterface

`default_nettype wire

// File: src/ibufPkg.sv
// Instruction packet type and configuration field types
`default_nettype none
`include "ibuf_consts.svh"

package ibufPkg;

	// One decoded instruction as the buffer sees it
	typedef struct packed {
		logic                      valid;
		logic                      isCsr;
		logic                      exception;
		logic                      isLoad;
		logic                      isStore;
		// Opaque tag, carried through unchanged
		logic [`PAYLOAD_WIDTH-1:0] payload;
	} ibufPacket;

	// Slot index into the queue storage
	typedef logic [`INST_QUEUE_LOG-1:0] queueIndex;

	// One extra bit so that a completely full queue fits
	typedef logic [`INST_QUEUE_LOG:0] queueCount;

	// Lane or partition count, holds up to 4
	typedef logic [`DISPATCH_LOG:0] laneCount;

	// Active lane masks, contiguous from lane 0
	typedef logic [`FETCH_WIDTH-1:0] fetchMask;
	typedef logic [`DISPATCH_WIDTH-1:0] dispatchMask;

endpackage

`default_nettype wire

// File: src/ibufStorage.sv
// Multi-port queue storage, synchronous writes and combinational reads
`default_nettype none
`include "ibuf_consts.svh"

module ibufStorage (
	input  wire                        clk,
	ibufWriteIf.sink                   wr,
	input  wire  ibufPkg::queueIndex   rdAddr_i [0:`DISPATCH_WIDTH-1],
	output ibufPkg::ibufPacket         rdData_o [0:`DISPATCH_WIDTH-1]
);
	// Packet array, contents only meaningful between head and tail
	ibufPkg::ibufPacket mem [0:`INST_QUEUE-1];

	// Compacted addresses never collide within one cycle
	always_ff @(posedge clk)
	begin
		for (int p = 0; p < `WRITE_PORTS; p++)
		begin
			if (wr.wrEn[p])
				mem[wr.wrAddr[p]] <= wr.wrData[p];
		end
	end

	// One read port per dispatch lane
	always_comb
	begin
		for (int i = 0; i < `DISPATCH_WIDTH; i++)
			rdData_o[i] = mem[rdAddr_i[i]];
	end

endmodule

`default_nettype wire

// File: src/ibufWriteAlloc.sv
// Tail pointer, compacted write addresses and full flag
`default_nettype none
`include "ibuf_consts.svh"

module ibufWriteAlloc (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        flush_i,
	input  wire                        decodeReady_i,
	input  wire  ibufPkg::ibufPacket   packets_i [0:`WRITE_PORTS-1],
	input  wire  ibufPkg::queueCount   count_i,
	ibufCfgIf.sink                     cfg,
	ibufWriteIf.source                 wr,
	output logic                       full_o
);
	// Each fetch lane owns a pair of write ports
	localparam int portsPerLane = `WRITE_PORTS / `FETCH_WIDTH;

	ibufPkg::queueIndex  tailPtr;
	ibufPkg::queueCount  tailSum;
	ibufPkg::queueCount  fullLimit;
	logic                portValid [0:`WRITE_PORTS-1];
	logic                accept;

	// Leave room for two packets per active fetch lane
	assign fullLimit = cfg.queueSize - (ibufPkg::queueCount'(cfg.numFetchLanes) << 1);
	assign full_o    = count_i > fullLimit;
	assign accept    = decodeReady_i & ~full_o;

	// Valid packets take consecutive slots after the tail, holes skipped
	always_comb
	begin
		ibufPkg::queueCount slot;
		ibufPkg::laneCount  written;
		slot    = ibufPkg::queueCount'(tailPtr);
		written = '0;
		for (int p = 0; p < `WRITE_PORTS; p++)
		begin
			// Ports of an inactive fetch lane carry nothing
			portValid[p] = packets_i[p].valid & cfg.fetchLaneMask[p / portsPerLane];
			wr.wrEn[p]   = accept & portValid[p];
			wr.wrData[p] = packets_i[p];
			// Wrap at the configured size, not the physical depth
			if (slot >= cfg.queueSize)
				wr.wrAddr[p] = ibufPkg::queueIndex'(slot - cfg.queueSize);
			else
				wr.wrAddr[p] = ibufPkg::queueIndex'(slot);
			slot    = slot + ibufPkg::queueCount'(portValid[p]);
			written = written + ibufPkg::laneCount'(wr.wrEn[p]);
		end
		wr.numWritten = written;
	end

	assign tailSum = ibufPkg::queueCount'(tailPtr) + ibufPkg::queueCount'(wr.numWritten);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			tailPtr <= '0;
		else if (flush_i)
			tailPtr <= '0;
		else if (tailSum >= cfg.queueSize)
			tailPtr <= ibufPkg::queueIndex'(tailSum - cfg.queueSize);
		else
			tailPtr <= ibufPkg::queueIndex'(tailSum);
	end

endmodule

`default_nettype wire

// File: src/ibuf_consts.svh
// Width, depth and register map constants for the instruction buffer
`ifndef IBUF_CONSTS_SVH
`define IBUF_CONSTS_SVH

// Front end delivers two packets per fetch lane
`define FETCH_WIDTH     2
`define WRITE_PORTS     4

// Dispatch bundle width and its log
`define DISPATCH_WIDTH  4
`define DISPATCH_LOG    2

// Physical queue depth, split into equal partitions of 8
`define INST_QUEUE      32
`define INST_QUEUE_LOG  5
`define QUEUE_PARTS     4

`define PAYLOAD_WIDTH   32

// Wishbone slave widths and register offsets
`define WB_ADR_WIDTH    4
`define WB_DAT_WIDTH    32
`define REG_LANES       4'd0
`define REG_PARTS       4'd1
`define REG_COUNT       4'd2

`endif

// File: src/instBuffer.sv
// Instruction buffer top level, plain ports around the four blocks
`default_nettype none
`include "ibuf_consts.svh"

module instBuffer (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        flush_i,
	input  wire                        stall_i,
	input  wire                        commitCsr_i,
	input  wire                        decodeReady_i,
	input  wire  ibufPkg::ibufPacket   ibPacket_i [0:`WRITE_PORTS-1],
	input  wire                        wbCyc_i,
	input  wire                        wbStb_i,
	input  wire                        wbWe_i,
	input  wire  [`WB_ADR_WIDTH-1:0]   wbAdr_i,
	input  wire  [`WB_DAT_WIDTH-1:0]   wbDat_i,
	output logic                       instBufferFull_o,
	output logic                       instBufferReady_o,
	output logic                       stallForCsr_o,
	output logic                       insufficientCnt_o,
	output ibufPkg::queueCount         instCount_o,
	output ibufPkg::ibufPacket         renPacket_o [0:`DISPATCH_WIDTH-1],
	output logic [`WB_DAT_WIDTH-1:0]   wbDat_o,
	output logic                       wbAck_o
);
	ibufCfgIf    cfgIf ();
	ibufWriteIf  wrIf ();

	ibufPkg::queueCount  instCount;
	ibufPkg::queueIndex  rdAddr [0:`DISPATCH_WIDTH-1];
	ibufPkg::ibufPacket  rdData [0:`DISPATCH_WIDTH-1];

	// Settings, also reads back occupancy
	ibufConfigRegs cfgRegs (
		.clk     (clk),
		.reset   (reset),
		.wbCyc_i (wbCyc_i),
		.wbStb_i (wbStb_i),
		.wbWe_i  (wbWe_i),
		.wbAdr_i (wbAdr_i),
		.wbDat_i (wbDat_i),
		.count_i (instCount),
		.wbDat_o (wbDat_o),
		.wbAck_o (wbAck_o),
		.cfg     (cfgIf.source)
	);

	// Tail side
	ibufWriteAlloc writeAlloc (
		.clk           (clk),
		.reset         (reset),
		.flush_i       (flush_i),
		.decodeReady_i (decodeReady_i),
		.packets_i     (ibPacket_i),
		.count_i       (instCount),
		.cfg           (cfgIf.sink),
		.wr            (wrIf.source),
		.full_o        (instBufferFull_o)
	);

	ibufStorage storage (
		.clk      (clk),
		.wr       (wrIf.sink),
		.rdAddr_i (rdAddr),
		.rdData_o (rdData)
	);

	// Head side
	ibufDispatchCtrl dispatchCtrl (
		.clk            (clk),
		.reset          (reset),
		.flush_i        (flush_i),
		.stall_i        (stall_i),
		.commitCsr_i    (commitCsr_i),
		.numWritten_i   (wrIf.numWritten),
		.rdData_i       (rdData),
		.cfg            (cfgIf.sink),
		.rdAddr_o       (rdAddr),
		.count_o        (instCount),
		.ready_o        (instBufferReady_o),
		.stallForCsr_o  (stallForCsr_o),
		.insufficient_o (insufficientCnt_o),
		.renPacket_o    (renPacket_o)
	);

	assign instCount_o = instCount;

endmodule

`default_nettype wire

// File: testbench/ibufTb.sv
// Instruction buffer testbench with reference queue model, assertions and watchdog
`default_nettype none
`include "ibuf_consts.svh"

module ibufTb;
	localparam int clkPeriod    = 100;
	localparam int portsPerLane = `WRITE_PORTS / `FETCH_WIDTH;
	localparam int randCycles   = 60;
	localparam int fillCycles   = 12;
	localparam int drainCycles  = 14;
	localparam int csrCycles    = 24;
	localparam int flushCycles  = 30;
	localparam int cfgCycles    = 80;
	// Bus transfers, flushes and reset come on top of the loops
	localparam int totalCycles  = randCycles + fillCycles + drainCycles + csrCycles +
		flushCycles + cfgCycles + 60;

	logic                       clk;
	logic                       reset;
	logic                       flush;
	logic                       stall;
	logic                       commitCsr;
	logic                       decodeReady;
	ibufPkg::ibufPacket         inPkt [0:`WRITE_PORTS-1];
	logic                       wbCyc;
	logic                       wbStb;
	logic                       wbWe;
	logic [`WB_ADR_WIDTH-1:0]   wbAdr;
	logic [`WB_DAT_WIDTH-1:0]   wbDatIn;
	logic                       full;
	logic                       ready;
	logic                       stallCsr;
	logic                       insufficient;
	ibufPkg::queueCount         count;
	ibufPkg::ibufPacket         outPkt [0:`DISPATCH_WIDTH-1];
	logic [`WB_DAT_WIDTH-1:0]   wbDatOut;
	logic                       wbAck;

	// Reference model of queue contents, holds and settings
	ibufPkg::ibufPacket         modelQ [$];
	logic                       modelCsrHold;
	logic                       modelExcHold;
	logic                       modelAck;
	int                         nDisp;
	int                         nFetch;
	int                         qSize;
	int                         nextTag;
	logic [`WB_DAT_WIDTH-1:0]   lastRead;

	instBuffer dut_i (
		.clk               (clk),
		.reset             (reset),
		.flush_i           (flush),
		.stall_i           (stall),
		.commitCsr_i       (commitCsr),
		.decodeReady_i     (decodeReady),
		.ibPacket_i        (inPkt),
		.wbCyc_i           (wbCyc),
		.wbStb_i           (wbStb),
		.wbWe_i            (wbWe),
		.wbAdr_i           (wbAdr),
		.wbDat_i           (wbDatIn),
		.instBufferFull_o  (full),
		.instBufferReady_o (ready),
		.stallForCsr_o     (stallCsr),
		.insufficientCnt_o (insufficient),
		.instCount_o       (count),
		.renPacket_o       (outPkt),
		.wbDat_o           (wbDatOut),
		.wbAck_o           (wbAck)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clkPeriod / 2) clk = ~clk;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkVal(input string testName, input string what,
		input logic [63:0] expVal, input logic [63:0] actVal);
		assert (expVal === actVal)
		else
			failRun($sformatf("** Error %s: %s expected %0h actual %0h",
				testName, what, expVal, actVal));
	endtask

	// Written counts land in 1 .. maxVal
	function automatic int clampCount(input int value, input int maxVal);
		int result;
		result = value;
		if (value == 0)
			result = 1;
		else if (value > maxVal)
			result = maxVal;
		return result;
	endfunction

	task automatic applyWrite(input logic [`WB_ADR_WIDTH-1:0] adr,
		input logic [`WB_DAT_WIDTH-1:0] data);
		if (adr == `REG_LANES)
		begin
			nDisp  = clampCount(int'(data[2:0]), `DISPATCH_WIDTH);
			nFetch = clampCount(int'(data[5:4]), `FETCH_WIDTH);
		end
		else if (adr == `REG_PARTS)
			qSize = clampCount(int'(data[2:0]), `QUEUE_PARTS) * (`INST_QUEUE / `QUEUE_PARTS);
	endtask

	// One clock: check outputs mid cycle, then advance the model to the next edge
	task automatic tick(input string testName);
		int                  cnt;
		int                  nOut;
		int                  cntNext;
		logic                expFull;
		logic                expReady;
		logic                csrOut;
		logic                excOut;
		ibufPkg::ibufPacket  got;
		ibufPkg::ibufPacket  arrived [$];
		#10;
		cnt      = modelQ.size();
		expFull  = cnt > qSize - 2 * nFetch;
		expReady = cnt >= nDisp && !stall && !modelCsrHold && !modelExcHold;
		nOut     = 0;
		csrOut   = 1'b0;
		excOut   = 1'b0;
		// Bundle closes after a CSR or excepting entry
		if (expReady)
		begin
			for (int i = 0; i < nDisp; i++)
			begin
				nOut++;
				csrOut = csrOut | modelQ[i].isCsr;
				excOut = excOut | modelQ[i].exception;
				if (modelQ[i].isCsr || modelQ[i].exception)
					break;
			end
		end
		// Valid packets of active fetch lanes, taken only when not full
		if (decodeReady && !expFull)
		begin
			for (int p = 0; p < `WRITE_PORTS; p++)
			begin
				if (inPkt[p].valid && p / portsPerLane < nFetch)
					arrived.push_back(inPkt[p]);
			end
		end
		cntNext = cnt + arrived.size() - nOut;
		checkVal(testName, "count", 64'(cnt), 64'(count));
		checkVal(testName, "full", 64'(expFull), 64'(full));
		checkVal(testName, "ready", 64'(expReady), 64'(ready));
		checkVal(testName, "stallForCsr", 64'(modelCsrHold | modelExcHold), 64'(stallCsr));
		checkVal(testName, "insufficient", 64'(cnt < nDisp && cntNext < nDisp),
			64'(insufficient));
		checkVal(testName, "wishbone ack", 64'(modelAck), 64'(wbAck));
		for (int i = 0; i < `DISPATCH_WIDTH; i++)
		begin
			got = outPkt[i];
			if (i < nOut)
				checkVal(testName, $sformatf("lane %0d packet", i), 64'(modelQ[i]), 64'(got));
			else
				checkVal(testName, $sformatf("lane %0d flags", i), 64'(0),
					64'({got.valid, got.isCsr, got.exception, got.isLoad, got.isStore}));
		end
		if (wbAck)
			lastRead = wbDatOut;
		// Model state after the coming edge
		if (flush)
		begin
			modelQ.delete();
			modelCsrHold = 1'b0;
			modelExcHold = 1'b0;
		end
		else
		begin
			repeat (nOut)
				void'(modelQ.pop_front());
			foreach (arrived[k])
				modelQ.push_back(arrived[k]);
			if (commitCsr)
				modelCsrHold = 1'b0;
			else if (csrOut)
				modelCsrHold = 1'b1;
			if (excOut)
				modelExcHold = 1'b1;
		end
		if (wbCyc && wbStb && !modelAck && wbWe)
			applyWrite(wbAdr, wbDatIn);
		modelAck = wbCyc && wbStb && !modelAck;
		@(negedge clk);
	endtask

	task automatic clearGroup();
		for (int p = 0; p < `WRITE_PORTS; p++)
			inPkt[p] = '0;
	endtask

	// Random group, tags numbered in arrival order, optional CSR or exception lane
	task automatic driveGroup(input int validPct, input int csrLane, input int excLane);
		for (int p = 0; p < `WRITE_PORTS; p++)
		begin
			inPkt[p]           = '0;
			inPkt[p].valid     = int'($urandom % 100) < validPct || p == csrLane || p == excLane;
			inPkt[p].isLoad    = 1'($urandom);
			inPkt[p].isStore   = 1'($urandom);
			inPkt[p].isCsr     = p == csrLane;
			inPkt[p].exception = p == excLane;
			inPkt[p].payload   = 32'(nextTag);
			if (inPkt[p].valid)
				nextTag++;
		end
	endtask

	task automatic flushQueue(input string testName);
		clearGroup();
		flush = 1'b1;
		tick(testName);
		flush = 1'b0;
	endtask

	// Request cycle, then the ack cycle with read data
	task automatic wbAccess(input logic we, input logic [`WB_ADR_WIDTH-1:0] adr,
		input logic [`WB_DAT_WIDTH-1:0] data);
		wbCyc   = 1'b1;
		wbStb   = 1'b1;
		wbWe    = we;
		wbAdr   = adr;
		wbDatIn = data;
		tick("wishbone");
		tick("wishbone");
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe  = 1'b0;
	endtask

	task automatic wbReadCheck(input logic [`WB_ADR_WIDTH-1:0] adr,
		input logic [`WB_DAT_WIDTH-1:0] expVal);
		wbAccess(1'b0, adr, '0);
		checkVal("wishbone", $sformatf("register %0d", adr), 64'(expVal), 64'(lastRead));
	endtask

	initial
	begin
		#(totalCycles * clkPeriod);
		failRun("Timeout: the tests did not finish in the expected number of cycles");
	end

	initial
	begin
		void'($urandom(32'hffbc));
		reset        = 1'b1;
		flush        = 1'b0;
		stall        = 1'b0;
		commitCsr    = 1'b0;
		decodeReady  = 1'b0;
		wbCyc        = 1'b0;
		wbStb        = 1'b0;
		wbWe         = 1'b0;
		wbAdr        = '0;
		wbDatIn      = '0;
		clearGroup();
		modelCsrHold = 1'b0;
		modelExcHold = 1'b0;
		modelAck     = 1'b0;
		nDisp        = `DISPATCH_WIDTH;
		nFetch       = `FETCH_WIDTH;
		qSize        = `INST_QUEUE;
		nextTag      = 1;
		lastRead     = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		tick("reset");

		// Order, compaction and readiness under random stall and holes
		for (int c = 0; c < randCycles; c++)
		begin
			decodeReady = int'($urandom % 100) < 90;
			stall       = int'($urandom % 100) < 20;
			driveGroup(60, -1, -1);
			tick("order");
		end

		// Fill past full with dispatch held, then drain
		flushQueue("full");
		decodeReady = 1'b1;
		stall       = 1'b1;
		for (int c = 0; c < fillCycles; c++)
		begin
			driveGroup(100, -1, -1);
			tick("full");
		end
		stall = 1'b0;
		clearGroup();
		for (int c = 0; c < drainCycles; c++)
			tick("full drain");

		// CSR in lane 1 closes the bundle and holds until commit
		flushQueue("csr");
		driveGroup(100, 1, -1);
		tick("csr");
		clearGroup();
		repeat (6) tick("csr hold");
		commitCsr = 1'b1;
		tick("csr commit");
		commitCsr = 1'b0;
		driveGroup(100, -1, -1);
		tick("csr resume");
		clearGroup();
		repeat (3) tick("csr resume");

		// Exception hold survives commit and ends only with flush
		flushQueue("exception");
		driveGroup(100, -1, 2);
		tick("exception");
		clearGroup();
		repeat (4) tick("exception hold");
		commitCsr = 1'b1;
		tick("exception commit");
		commitCsr = 1'b0;
		tick("exception hold");
		flushQueue("exception flush");
		tick("exception flush");

		// Flush with a group on the inputs, then fresh traffic
		stall = 1'b1;
		for (int c = 0; c < 4; c++)
		begin
			driveGroup(100, -1, -1);
			tick("flush fill");
		end
		stall = 1'b0;
		flush = 1'b1;
		driveGroup(100, -1, -1);
		tick("flush");
		flush = 1'b0;
		clearGroup();
		tick("flush");
		for (int c = 0; c < flushCycles - 6; c++)
		begin
			stall = int'($urandom % 100) < 20;
			driveGroup(70, -1, -1);
			tick("flush order");
		end

		// Two dispatch lanes, one fetch lane, two partitions
		stall = 1'b0;
		flushQueue("config");
		// Written counts above the limit or zero saturate into range
		wbAccess(1'b1, `REG_LANES, 32'h37);
		wbAccess(1'b1, `REG_PARTS, 32'h0);
		wbReadCheck(`REG_LANES, 32'h24);
		wbReadCheck(`REG_PARTS, 32'h1);
		wbAccess(1'b1, `REG_LANES, 32'h12);
		wbAccess(1'b1, `REG_PARTS, 32'h2);
		wbReadCheck(`REG_LANES, 32'h12);
		wbReadCheck(`REG_PARTS, 32'h2);
		for (int c = 0; c < cfgCycles - 24; c++)
		begin
			stall = int'($urandom % 100) < 20;
			driveGroup(70, -1, -1);
			tick("config order");
		end
		// Threshold 14 with one fetch lane in a 16 entry queue
		stall = 1'b1;
		for (int c = 0; c < 10; c++)
		begin
			driveGroup(100, -1, -1);
			tick("config full");
		end
		// Occupancy readback while nothing enters or leaves
		clearGroup();
		wbReadCheck(`REG_COUNT, 32'(modelQ.size()));
		stall = 1'b0;
		for (int c = 0; c < 12; c++)
			tick("config drain");

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
